// ==== all.f ====
+incdir+.
rs_pkg.sv
dispatch_if.sv
rs_cdb_bypass.sv
rs_entry.sv
rs_alloc.sv
rs_issue_select.sv
rs_station.sv
rs_assertions.sv
tb_rs_station.sv

// ==== dispatch_if.sv ====
`timescale 1ns/10ps
`include "rs_defines.svh"

// one cycle of dispatch, already corrected against the CDB
interface dispatch_if;
    import rs_pkg::*;

    logic [`RS_WAYS-1:0]         load;
    operand_u [`RS_WAYS-1:0]     opa;
    operand_u [`RS_WAYS-1:0]     opb;
    logic [`RS_WAYS-1:0]         opa_valid;   // 1 means value, 0 means tag
    logic [`RS_WAYS-1:0]         opb_valid;
    rs_payload_t [`RS_WAYS-1:0]  payload;

    modport source (
        output load,
        output opa,
        output opb,
        output opa_valid,
        output opb_valid,
        output payload
    );

    modport sink (
        input load,
        input opa,
        input opb,
        input opa_valid,
        input opb_valid,
        input payload
    );

endinterface

// ==== rs_alloc.sv ====
`timescale 1ns/10ps
`include "rs_defines.svh"

module rs_alloc (
    input  logic                                     clock,
    input  logic                                     reset,
    dispatch_if.sink                                 disp,
    input  logic [`RS_ENTRIES-1:0]                   entry_free,
    input  logic [`RS_CNT_W-1:0]                     issue_count,
    output logic [`RS_ENTRIES-1:0]                   entry_load,
    output rs_pkg::operand_u [`RS_ENTRIES-1:0]       entry_opa,
    output rs_pkg::operand_u [`RS_ENTRIES-1:0]       entry_opb,
    output logic [`RS_ENTRIES-1:0]                   entry_opa_valid,
    output logic [`RS_ENTRIES-1:0]                   entry_opb_valid,
    output rs_pkg::rs_payload_t [`RS_ENTRIES-1:0]    entry_payload,
    output logic [`RS_CNT_W-1:0]                     num_free
);

    logic [`RS_CNT_W-1:0] load_count;

    // loaded ways in way order go to the lowest free entries
    always_comb begin
        logic [`RS_WAYS-1:0] pending;
        logic                granted;
        int                  n;
        pending         = disp.load;
        n               = 0;
        entry_load      = '0;
        entry_opa       = '0;
        entry_opb       = '0;
        entry_opa_valid = '0;
        entry_opb_valid = '0;
        entry_payload   = '0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            granted = 1'b0;
            for (int w = 0; w < `RS_WAYS; w++) begin
                if (entry_free[i] && pending[w] && !granted) begin
                    granted            = 1'b1;
                    pending[w]         = 1'b0;   // way taken
                    entry_load[i]      = 1'b1;
                    entry_opa[i]       = disp.opa[w];
                    entry_opb[i]       = disp.opb[w];
                    entry_opa_valid[i] = disp.opa_valid[w];
                    entry_opb_valid[i] = disp.opb_valid[w];
                    entry_payload[i]   = disp.payload[w];
                    n                  = n + 1;
                end
            end
        end
        load_count = `RS_CNT_W'(n);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            num_free <= `RS_CNT_W'(`RS_ENTRIES);
        end else begin
            num_free <= num_free - load_count + issue_count;
        end
    end

endmodule

// ==== rs_assertions.sv ====
`timescale 1ns/10ps
`include "rs_defines.svh"

module rs_assertions (
    input logic                    clock,
    input logic                    reset,
    input logic [`RS_WAYS-1:0]     load,
    input logic [`RS_CNT_W-1:0]    num_free,
    input logic [`RS_ENTRIES-1:0]  entry_free,
    input logic [`RS_ENTRIES-1:0]  entry_load,
    input logic [`RS_ENTRIES-1:0]  entry_clear,
    input logic [`RS_WAYS-1:0]     issue_valid
);

    free_count_matches: assert property (@(posedge clock) disable iff (reset)
        num_free == `RS_CNT_W'($countones(entry_free)))
        else $error("num_free differs from the count of free entries");

    // dispatcher must not overrun the station
    load_within_free: assert property (@(posedge clock) disable iff (reset)
        `RS_CNT_W'($countones(load)) <= num_free)
        else $error("more loads than free entries");

    no_load_and_clear: assert property (@(posedge clock) disable iff (reset)
        (entry_load & entry_clear) == '0)
        else $error("entry loaded and cleared in one cycle");

    issue_contiguous: assert property (@(posedge clock) disable iff (reset)
        issue_valid == 3'b000 || issue_valid == 3'b001 ||
        issue_valid == 3'b011 || issue_valid == 3'b111)
        else $error("issue lanes not filled from lane 0");

endmodule

bind rs_station rs_assertions u_assertions (
    .clock       (clock),
    .reset       (reset),
    .load        (load),
    .num_free    (num_free),
    .entry_free  (entry_free),
    .entry_load  (entry_load),
    .entry_clear (entry_clear),
    .issue_valid (issue_valid)
);

// ==== rs_cdb_bypass.sv ====
`timescale 1ns/10ps
`include "rs_defines.svh"

module rs_cdb_bypass (
    input  logic [`RS_WAYS-1:0]                      cdb_valid,
    input  logic [`RS_WAYS-1:0][`RS_PRF_W-1:0]       cdb_tag,
    input  logic [`RS_WAYS-1:0][`RS_REG_LEN-1:0]     cdb_data,
    input  logic [`RS_WAYS-1:0]                      load,
    input  rs_pkg::operand_u [`RS_WAYS-1:0]          opa,
    input  rs_pkg::operand_u [`RS_WAYS-1:0]          opb,
    input  logic [`RS_WAYS-1:0]                      opa_valid,
    input  logic [`RS_WAYS-1:0]                      opb_valid,
    input  logic [`RS_WAYS-1:0][`RS_PCLEN-1:0]       pc,
    input  rs_pkg::alu_func_e [`RS_WAYS-1:0]         op,
    input  logic [`RS_WAYS-1:0][`RS_OLEN-1:0]        offset,
    input  logic [`RS_WAYS-1:0]                      rd_mem,
    input  logic [`RS_WAYS-1:0]                      wr_mem,
    input  logic [`RS_WAYS-1:0][`RS_PRF_W-1:0]       dest_tag,
    input  logic [`RS_WAYS-1:0][`RS_ROB_W-1:0]       rob_idx,
    dispatch_if.source                               disp
);
    import rs_pkg::*;

    operand_u [`RS_WAYS-1:0] opa_fwd;
    operand_u [`RS_WAYS-1:0] opb_fwd;
    logic [`RS_WAYS-1:0]     opa_valid_fwd;
    logic [`RS_WAYS-1:0]     opb_valid_fwd;

    // catch results broadcast in the dispatch cycle itself
    always_comb begin
        opa_fwd       = opa;
        opb_fwd       = opb;
        opa_valid_fwd = opa_valid;
        opb_valid_fwd = opb_valid;
        for (int w = 0; w < `RS_WAYS; w++) begin
            for (int c = 0; c < `RS_WAYS; c++) begin
                if (!opa_valid[w] && cdb_valid[c] && cdb_tag[c] == opa[w].phys.tag) begin
                    opa_fwd[w].value = cdb_data[c];
                    opa_valid_fwd[w] = 1'b1;
                end
                if (!opb_valid[w] && cdb_valid[c] && cdb_tag[c] == opb[w].phys.tag) begin
                    opb_fwd[w].value = cdb_data[c];
                    opb_valid_fwd[w] = 1'b1;
                end
            end
        end
    end

    assign disp.load      = load;
    assign disp.opa       = opa_fwd;
    assign disp.opb       = opb_fwd;
    assign disp.opa_valid = opa_valid_fwd;
    assign disp.opb_valid = opb_valid_fwd;

    for (genvar w = 0; w < `RS_WAYS; w++) begin : g_payload
        assign disp.payload[w] = '{pc: pc[w], op: op[w], offset: offset[w],
                                   rd_mem: rd_mem[w], wr_mem: wr_mem[w],
                                   dest_tag: dest_tag[w], rob_idx: rob_idx[w]};
    end

endmodule

// ==== rs_defines.svh ====
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// lanes per cycle for dispatch, issue and the CDB
`define RS_WAYS      3
`define RS_ENTRIES   16

`define RS_REG_LEN   64
`define RS_PRF       64
`define RS_ROB       16
`define RS_OLEN      16
`define RS_PCLEN     32

`define RS_PRF_W     ($clog2(`RS_PRF))
`define RS_ROB_W     ($clog2(`RS_ROB))
`define RS_CNT_W     ($clog2(`RS_ENTRIES) + 1)  // must hold RS_ENTRIES itself

`endif

// ==== rs_entry.sv ====
`timescale 1ns/10ps
`include "rs_defines.svh"

module rs_entry (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic                                     load,
    input  logic                                     clear,
    input  logic [`RS_WAYS-1:0]                      cdb_valid,
    input  logic [`RS_WAYS-1:0][`RS_PRF_W-1:0]       cdb_tag,
    input  logic [`RS_WAYS-1:0][`RS_REG_LEN-1:0]     cdb_data,
    input  rs_pkg::operand_u                         opa_in,
    input  rs_pkg::operand_u                         opb_in,
    input  logic                                     opa_valid_in,
    input  logic                                     opb_valid_in,
    input  rs_pkg::rs_payload_t                      payload_in,
    output logic                                     ready,
    output logic                                     free,
    output rs_pkg::operand_u                         opa,
    output rs_pkg::operand_u                         opb,
    output rs_pkg::rs_payload_t                      payload
);
    import rs_pkg::*;

    logic     occupied;
    logic     opa_valid;
    logic     opb_valid;
    operand_u opa_next;
    operand_u opb_next;
    logic     opa_valid_next;
    logic     opb_valid_next;

    // wakeup
    always_comb begin
        opa_next       = opa;
        opb_next       = opb;
        opa_valid_next = opa_valid;
        opb_valid_next = opb_valid;
        for (int c = 0; c < `RS_WAYS; c++) begin
            if (!opa_valid && cdb_valid[c] && cdb_tag[c] == opa.phys.tag) begin
                opa_next.value = cdb_data[c];
                opa_valid_next = 1'b1;
            end
            if (!opb_valid && cdb_valid[c] && cdb_tag[c] == opb.phys.tag) begin
                opb_next.value = cdb_data[c];
                opb_valid_next = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            occupied  <= 1'b0;
            opa_valid <= 1'b0;
            opb_valid <= 1'b0;
        end else if (load) begin
            occupied  <= 1'b1;
            opa_valid <= opa_valid_in;
            opb_valid <= opb_valid_in;
        end else if (clear) begin
            occupied  <= 1'b0;              // issued this cycle
        end else if (occupied) begin
            opa_valid <= opa_valid_next;
            opb_valid <= opb_valid_next;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            opa     <= opa_in;
            opb     <= opb_in;
            payload <= payload_in;
        end else if (occupied) begin
            opa <= opa_next;
            opb <= opb_next;
        end
    end

    assign free  = ~occupied;
    assign ready = occupied & opa_valid & opb_valid;

endmodule

// ==== rs_issue_select.sv ====
`timescale 1ns/10ps
`include "rs_defines.svh"

module rs_issue_select (
    input  logic [`RS_ENTRIES-1:0]                   entry_ready,
    input  rs_pkg::operand_u [`RS_ENTRIES-1:0]       entry_opa,
    input  rs_pkg::operand_u [`RS_ENTRIES-1:0]       entry_opb,
    input  rs_pkg::rs_payload_t [`RS_ENTRIES-1:0]    entry_payload,
    output logic [`RS_ENTRIES-1:0]                   entry_clear,
    output logic [`RS_CNT_W-1:0]                     issue_count,
    output logic [`RS_WAYS-1:0]                      issue_valid,
    output rs_pkg::operand_u [`RS_WAYS-1:0]          issue_opa,
    output rs_pkg::operand_u [`RS_WAYS-1:0]          issue_opb,
    output rs_pkg::rs_payload_t [`RS_WAYS-1:0]       issue_payload
);

    // lowest index first, lanes fill from 0 upward
    always_comb begin
        int lane;
        lane          = 0;
        entry_clear   = '0;
        issue_valid   = '0;
        issue_opa     = '0;
        issue_opb     = '0;
        issue_payload = '0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (entry_ready[i] && lane < `RS_WAYS) begin
                entry_clear[i]      = 1'b1;
                issue_valid[lane]   = 1'b1;
                issue_opa[lane]     = entry_opa[i];
                issue_opb[lane]     = entry_opb[i];
                issue_payload[lane] = entry_payload[i];
                lane                = lane + 1;
            end
        end
        issue_count = `RS_CNT_W'(lane);   // back into the free counter
    end

endmodule

// ==== rs_pkg.sv ====
`include "rs_defines.svh"

package rs_pkg;

    typedef enum logic [3:0] {
        ALU_ADD = 4'h0,
        ALU_SUB = 4'h1,
        ALU_AND = 4'h2,
        ALU_OR  = 4'h3,
        ALU_XOR = 4'h4,
        ALU_SLL = 4'h5,
        ALU_SRL = 4'h6,
        ALU_CMP = 4'h7
    } alu_func_e;

    // value when the operand valid bit is set, else a physical register tag
    typedef union packed {
        logic [`RS_REG_LEN-1:0] value;
        struct packed {
            logic [`RS_REG_LEN-`RS_PRF_W-1:0] pad;
            logic [`RS_PRF_W-1:0]             tag;
        } phys;
    } operand_u;

    // carried untouched from dispatch to issue
    typedef struct packed {
        logic [`RS_PCLEN-1:0]  pc;
        alu_func_e             op;
        logic [`RS_OLEN-1:0]   offset;
        logic                  rd_mem;
        logic                  wr_mem;
        logic [`RS_PRF_W-1:0]  dest_tag;
        logic [`RS_ROB_W-1:0]  rob_idx;
    } rs_payload_t;

endpackage

// ==== rs_station.sv ====
`timescale 1ns/10ps
`include "rs_defines.svh"

module rs_station (
    input  logic                                     clock,
    input  logic                                     reset,
    // common data bus
    input  logic [`RS_WAYS-1:0]                      cdb_valid,
    input  logic [`RS_WAYS-1:0][`RS_PRF_W-1:0]       cdb_tag,
    input  logic [`RS_WAYS-1:0][`RS_REG_LEN-1:0]     cdb_data,
    // dispatch
    input  logic [`RS_WAYS-1:0]                      load,
    input  logic [`RS_WAYS-1:0][`RS_REG_LEN-1:0]     opa,        // value or tag
    input  logic [`RS_WAYS-1:0][`RS_REG_LEN-1:0]     opb,
    input  logic [`RS_WAYS-1:0]                      opa_valid,  // set when opa is a value
    input  logic [`RS_WAYS-1:0]                      opb_valid,
    input  logic [`RS_WAYS-1:0][`RS_PCLEN-1:0]       pc,
    input  rs_pkg::alu_func_e [`RS_WAYS-1:0]         op,
    input  logic [`RS_WAYS-1:0][`RS_OLEN-1:0]        offset,
    input  logic [`RS_WAYS-1:0]                      rd_mem,
    input  logic [`RS_WAYS-1:0]                      wr_mem,
    input  logic [`RS_WAYS-1:0][`RS_PRF_W-1:0]       dest_tag,
    input  logic [`RS_WAYS-1:0][`RS_ROB_W-1:0]       rob_idx,
    // issue
    output logic [`RS_WAYS-1:0]                      issue_valid,
    output logic [`RS_WAYS-1:0][`RS_REG_LEN-1:0]     issue_opa,
    output logic [`RS_WAYS-1:0][`RS_REG_LEN-1:0]     issue_opb,
    output logic [`RS_WAYS-1:0][`RS_PCLEN-1:0]       issue_pc,
    output rs_pkg::alu_func_e [`RS_WAYS-1:0]         issue_op,
    output logic [`RS_WAYS-1:0][`RS_OLEN-1:0]        issue_offset,
    output logic [`RS_WAYS-1:0]                      issue_rd_mem,
    output logic [`RS_WAYS-1:0]                      issue_wr_mem,
    output logic [`RS_WAYS-1:0][`RS_PRF_W-1:0]       issue_dest_tag,
    output logic [`RS_WAYS-1:0][`RS_ROB_W-1:0]       issue_rob_idx,
    output logic [`RS_CNT_W-1:0]                     num_free
);
    import rs_pkg::*;

    dispatch_if disp_bus ();

    logic [`RS_ENTRIES-1:0]        entry_load;
    logic [`RS_ENTRIES-1:0]        entry_clear;
    logic [`RS_ENTRIES-1:0]        entry_free;
    logic [`RS_ENTRIES-1:0]        entry_ready;
    operand_u [`RS_ENTRIES-1:0]    entry_opa_in;
    operand_u [`RS_ENTRIES-1:0]    entry_opb_in;
    logic [`RS_ENTRIES-1:0]        entry_opa_valid_in;
    logic [`RS_ENTRIES-1:0]        entry_opb_valid_in;
    rs_payload_t [`RS_ENTRIES-1:0] entry_payload_in;
    operand_u [`RS_ENTRIES-1:0]    entry_opa;
    operand_u [`RS_ENTRIES-1:0]    entry_opb;
    rs_payload_t [`RS_ENTRIES-1:0] entry_payload;
    logic [`RS_CNT_W-1:0]          issue_count;
    rs_payload_t [`RS_WAYS-1:0]    issue_payload;

    rs_cdb_bypass u_bypass (
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_data  (cdb_data),
        .load      (load),
        .opa       (opa),
        .opb       (opb),
        .opa_valid (opa_valid),
        .opb_valid (opb_valid),
        .pc        (pc),
        .op        (op),
        .offset    (offset),
        .rd_mem    (rd_mem),
        .wr_mem    (wr_mem),
        .dest_tag  (dest_tag),
        .rob_idx   (rob_idx),
        .disp      (disp_bus)
    );

    rs_alloc u_alloc (
        .clock           (clock),
        .reset           (reset),
        .disp            (disp_bus),
        .entry_free      (entry_free),
        .issue_count     (issue_count),
        .entry_load      (entry_load),
        .entry_opa       (entry_opa_in),
        .entry_opb       (entry_opb_in),
        .entry_opa_valid (entry_opa_valid_in),
        .entry_opb_valid (entry_opb_valid_in),
        .entry_payload   (entry_payload_in),
        .num_free        (num_free)
    );

    for (genvar i = 0; i < `RS_ENTRIES; i++) begin : g_entry
        rs_entry u_entry (
            .clock        (clock),
            .reset        (reset),
            .load         (entry_load[i]),
            .clear        (entry_clear[i]),
            .cdb_valid    (cdb_valid),
            .cdb_tag      (cdb_tag),
            .cdb_data     (cdb_data),
            .opa_in       (entry_opa_in[i]),
            .opb_in       (entry_opb_in[i]),
            .opa_valid_in (entry_opa_valid_in[i]),
            .opb_valid_in (entry_opb_valid_in[i]),
            .payload_in   (entry_payload_in[i]),
            .ready        (entry_ready[i]),
            .free         (entry_free[i]),
            .opa          (entry_opa[i]),
            .opb          (entry_opb[i]),
            .payload      (entry_payload[i])
        );
    end

    rs_issue_select u_select (
        .entry_ready   (entry_ready),
        .entry_opa     (entry_opa),
        .entry_opb     (entry_opb),
        .entry_payload (entry_payload),
        .entry_clear   (entry_clear),
        .issue_count   (issue_count),
        .issue_valid   (issue_valid),
        .issue_opa     (issue_opa),
        .issue_opb     (issue_opb),
        .issue_payload (issue_payload)
    );

    // split payload back out per lane
    for (genvar w = 0; w < `RS_WAYS; w++) begin : g_lane
        assign issue_pc[w]       = issue_payload[w].pc;
        assign issue_op[w]       = issue_payload[w].op;
        assign issue_offset[w]   = issue_payload[w].offset;
        assign issue_rd_mem[w]   = issue_payload[w].rd_mem;
        assign issue_wr_mem[w]   = issue_payload[w].wr_mem;
        assign issue_dest_tag[w] = issue_payload[w].dest_tag;
        assign issue_rob_idx[w]  = issue_payload[w].rob_idx;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_rs_station -f all.f -o sim_rs > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_rs > sim.log 2>&1
cat sim.log
grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log && exit 0 || exit 1

// ==== tb_rs_station.sv ====
`timescale 1ns/10ps
`include "rs_defines.svh"

module tb_rs_station;
    import rs_pkg::*;

    localparam int RUN_CYCLES   = 550;
    localparam int DRAIN_CYCLES = 20;
    localparam int CYCLE_LIMIT  = 600;   // reset + run + drain with margin

    logic clock;
    logic reset;
    logic [`RS_WAYS-1:0]                  cdb_valid;
    logic [`RS_WAYS-1:0][`RS_PRF_W-1:0]   cdb_tag;
    logic [`RS_WAYS-1:0][`RS_REG_LEN-1:0] cdb_data;
    logic [`RS_WAYS-1:0]                  load;
    logic [`RS_WAYS-1:0][`RS_REG_LEN-1:0] opa;
    logic [`RS_WAYS-1:0][`RS_REG_LEN-1:0] opb;
    logic [`RS_WAYS-1:0]                  opa_valid;
    logic [`RS_WAYS-1:0]                  opb_valid;
    logic [`RS_WAYS-1:0][`RS_PCLEN-1:0]   pc;
    alu_func_e [`RS_WAYS-1:0]             op;
    logic [`RS_WAYS-1:0][`RS_OLEN-1:0]    offset;
    logic [`RS_WAYS-1:0]                  rd_mem;
    logic [`RS_WAYS-1:0]                  wr_mem;
    logic [`RS_WAYS-1:0][`RS_PRF_W-1:0]   dest_tag;
    logic [`RS_WAYS-1:0][`RS_ROB_W-1:0]   rob_idx;
    logic [`RS_WAYS-1:0]                  issue_valid;
    logic [`RS_WAYS-1:0][`RS_REG_LEN-1:0] issue_opa;
    logic [`RS_WAYS-1:0][`RS_REG_LEN-1:0] issue_opb;
    logic [`RS_WAYS-1:0][`RS_PCLEN-1:0]   issue_pc;
    alu_func_e [`RS_WAYS-1:0]             issue_op;
    logic [`RS_WAYS-1:0][`RS_OLEN-1:0]    issue_offset;
    logic [`RS_WAYS-1:0]                  issue_rd_mem;
    logic [`RS_WAYS-1:0]                  issue_wr_mem;
    logic [`RS_WAYS-1:0][`RS_PRF_W-1:0]   issue_dest_tag;
    logic [`RS_WAYS-1:0][`RS_ROB_W-1:0]   issue_rob_idx;
    logic [`RS_CNT_W-1:0]                 num_free;

    // reference model of the entry array
    logic        m_occ [`RS_ENTRIES];
    logic        m_va  [`RS_ENTRIES];
    logic        m_vb  [`RS_ENTRIES];
    operand_u    m_a   [`RS_ENTRIES];
    operand_u    m_b   [`RS_ENTRIES];
    rs_payload_t m_p   [`RS_ENTRIES];
    int          sel   [`RS_WAYS];
    int          n_sel;
    int          cycles;

    rs_station u_rs_station (.*);

    initial clock = 1'b0;
    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $fatal(1, "timeout");
        end
    end

    task automatic stop_on_error();
        $display("Some tests failed");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic check_lane(input int lane, input operand_u got_a, input operand_u exp_a,
                              input operand_u got_b, input operand_u exp_b,
                              input rs_payload_t got_p, input rs_payload_t exp_p);
        if (got_a !== exp_a) begin
            $display("[ERROR] issue_opa[%0d] got %h expected %h", lane, got_a, exp_a);
            stop_on_error();
        end
        if (got_b !== exp_b) begin
            $display("[ERROR] issue_opb[%0d] got %h expected %h", lane, got_b, exp_b);
            stop_on_error();
        end
        if (got_p !== exp_p) begin
            $display("[ERROR] issue payload[%0d] got %h expected %h", lane, got_p, exp_p);
            stop_on_error();
        end
    endtask

    task automatic check_valid(input logic [`RS_WAYS-1:0] got, input logic [`RS_WAYS-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] issue_valid got %h expected %h", got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_free(input logic [`RS_CNT_W-1:0] got, input logic [`RS_CNT_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] num_free got %h expected %h", got, exp);
            stop_on_error();
        end
    endtask

    // tag operand picks up a matching CDB lane
    task automatic wake(inout operand_u x, inout logic v);
        for (int c = 0; c < `RS_WAYS; c++) begin
            if (!v && cdb_valid[c] && cdb_tag[c] == x.phys.tag) begin
                x.value = cdb_data[c];
                v       = 1'b1;
            end
        end
    endtask

    function automatic int free_count();
        int n;
        n = 0;
        for (int i = 0; i < `RS_ENTRIES; i++) n += m_occ[i] ? 0 : 1;
        return n;
    endfunction

    task automatic drive_cycle(input bit drain);
        int       room;
        int       base;
        operand_u x;
        room = free_count();
        base = $urandom % 8;
        for (int c = 0; c < `RS_WAYS; c++) begin
            cdb_valid[c] = drain ? 1'b1 : 1'($urandom % 2);
            cdb_tag[c]   = `RS_PRF_W'((base + c) % 8);   // distinct lanes, small tag set
            cdb_data[c]  = {$urandom, $urandom};
        end
        for (int w = 0; w < `RS_WAYS; w++) begin
            load[w] = !drain && room > 0 && ($urandom % 3 == 0);
            if (load[w]) room--;
            x.value      = {$urandom, $urandom};
            x.phys.tag   = `RS_PRF_W'($urandom % 8);
            opa[w]       = x;
            opa_valid[w] = 1'($urandom % 2);
            x.value      = {$urandom, $urandom};
            x.phys.tag   = `RS_PRF_W'($urandom % 8);
            opb[w]       = x;
            opb_valid[w] = 1'($urandom % 2);
            pc[w]        = $urandom;
            op[w]        = alu_func_e'(4'($urandom % 8));
            offset[w]    = 16'($urandom);
            rd_mem[w]    = 1'($urandom);
            wr_mem[w]    = 1'($urandom);
            dest_tag[w]  = `RS_PRF_W'($urandom);
            rob_idx[w]   = `RS_ROB_W'($urandom);
        end
    endtask

    task automatic check_cycle();
        logic [`RS_WAYS-1:0] exp_valid;
        rs_payload_t         got_p;
        n_sel     = 0;
        exp_valid = '0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (m_occ[i] && m_va[i] && m_vb[i] && n_sel < `RS_WAYS) begin
                sel[n_sel]       = i;
                exp_valid[n_sel] = 1'b1;
                n_sel++;
            end
        end
        check_free(num_free, `RS_CNT_W'(free_count()));
        check_valid(issue_valid, exp_valid);
        for (int l = 0; l < n_sel; l++) begin
            got_p = '{pc: issue_pc[l], op: issue_op[l], offset: issue_offset[l],
                      rd_mem: issue_rd_mem[l], wr_mem: issue_wr_mem[l],
                      dest_tag: issue_dest_tag[l], rob_idx: issue_rob_idx[l]};
            check_lane(l, issue_opa[l], m_a[sel[l]], issue_opb[l], m_b[sel[l]],
                       got_p, m_p[sel[l]]);
        end
    endtask

    // state change at the clock edge
    task automatic update_model();
        logic was_free [`RS_ENTRIES];
        int   w;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            was_free[i] = !m_occ[i];
            if (m_occ[i]) begin
                wake(m_a[i], m_va[i]);
                wake(m_b[i], m_vb[i]);
            end
        end
        for (int l = 0; l < n_sel; l++) m_occ[sel[l]] = 1'b0;
        w = 0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            while (w < `RS_WAYS && !load[w]) w++;
            if (was_free[i] && w < `RS_WAYS) begin
                m_occ[i] = 1'b1;
                m_a[i]   = opa[w];
                m_va[i]  = opa_valid[w];
                m_b[i]   = opb[w];
                m_vb[i]  = opb_valid[w];
                wake(m_a[i], m_va[i]);
                wake(m_b[i], m_vb[i]);
                m_p[i] = '{pc: pc[w], op: op[w], offset: offset[w], rd_mem: rd_mem[w],
                           wr_mem: wr_mem[w], dest_tag: dest_tag[w], rob_idx: rob_idx[w]};
                w++;
            end
        end
    endtask

    initial begin
        void'($urandom(95));
        cycles    = 0;
        reset     = 1'b1;
        cdb_valid = '0;
        cdb_tag   = '0;
        cdb_data  = '0;
        load      = '0;
        opa       = '0;
        opb       = '0;
        opa_valid = '0;
        opb_valid = '0;
        pc        = '0;
        op        = '{default: ALU_ADD};
        offset    = '0;
        rd_mem    = '0;
        wr_mem    = '0;
        dest_tag  = '0;
        rob_idx   = '0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            m_occ[i] = 1'b0;
            m_va[i]  = 1'b0;
            m_vb[i]  = 1'b0;
            m_a[i]   = '0;
            m_b[i]   = '0;
            m_p[i]   = '0;
        end
        repeat (2) @(posedge clock);
        #1 reset = 1'b0;
        for (int k = 0; k < RUN_CYCLES + DRAIN_CYCLES; k++) begin
            drive_cycle(k >= RUN_CYCLES);
            @(negedge clock);
            check_cycle();
            @(posedge clock);
            update_model();
            #1;
        end
        $display("All tests passed");
        $finish;
    end

endmodule
